//--- rtl/rename_consts.svh
////////////////////
// Sizes of the rename stage. All index widths follow from the sizes
// Physical register 0 is reserved as the hard zero register
////////////////////

`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// Group and commit widths
`define RENAME_WIDTH 2
`define COMMIT_WIDTH 2

// Register file sizes
`define ARF_SIZE 32
`define PRF_SIZE 64

// Branch checkpoints
`define CP_COUNT 4

`define ARF_INDEX_SIZE ($clog2(`ARF_SIZE))
`define PRF_INDEX_SIZE ($clog2(`PRF_SIZE))
`define CP_INDEX_SIZE ($clog2(`CP_COUNT))

`endif

//--- rtl/reg_pkg.sv
////////////////////
// Index types for architectural, physical and checkpoint registers
////////////////////

`default_nettype none

`include "rename_consts.svh"

package reg_pkg;

  // Architectural register number, x0 included
  typedef logic [`ARF_INDEX_SIZE-1:0] arf_index_t;

  // Physical register number
  typedef logic [`PRF_INDEX_SIZE-1:0] prf_index_t;

  // Checkpoint slot
  typedef logic [`CP_INDEX_SIZE-1:0] cp_index_t;

endpackage

`default_nettype wire

//--- rtl/rename_pkg.sv
////////////////////
// Group-level vectors and the table snapshot type
// Depends on reg_pkg being compiled first
////////////////////

`default_nettype none

`include "rename_consts.svh"

package rename_pkg;

  // Whole rename table, entry i holds the mapping of x<i>
  typedef reg_pkg::prf_index_t [`ARF_SIZE-1:0] map_snapshot_t;

  // One bit per architectural register
  typedef logic [`ARF_SIZE-1:0] arf_mask_t;

  // One bit per physical register
  typedef logic [`PRF_SIZE-1:0] prf_mask_t;

  // One bit per rename slot
  typedef logic [`RENAME_WIDTH-1:0] slot_mask_t;

endpackage

`default_nettype wire

//--- rtl/rename_ifs.sv
////////////////////
// Internal buses of the rename stage
// alloc_prf and snapshot_out are combinational on the provider side
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rename_consts.svh"

// Physical register allocation between table and free list
interface alloc_if;

  rename_pkg::slot_mask_t                     alloc_req;
  logic                                       alloc_fire;
  reg_pkg::prf_index_t [`RENAME_WIDTH-1:0]    alloc_prf;
  logic                                       allocatable;

  modport requester (
    output alloc_req,
    output alloc_fire,
    input  alloc_prf,
    input  allocatable
  );

  modport provider (
    input  alloc_req,
    input  alloc_fire,
    output alloc_prf,
    output allocatable
  );

endinterface

// Snapshot write and restore read
interface checkpoint_if;

  logic                         take;
  reg_pkg::cp_index_t           take_idx;
  rename_pkg::map_snapshot_t    snapshot_in;
  reg_pkg::cp_index_t           restore_idx;
  rename_pkg::map_snapshot_t    snapshot_out;

  modport writer (
    output take,
    output take_idx,
    output snapshot_in,
    output restore_idx,
    input  snapshot_out
  );

  modport holder (
    input  take,
    input  take_idx,
    input  snapshot_in,
    input  restore_idx,
    output snapshot_out
  );

endinterface

`default_nettype wire

//--- rtl/free_list.sv
////////////////////
// Bitmap free list. Hands out the lowest free indices in slot order
// allocatable needs RENAME_WIDTH free registers, whatever the request
// Physical 0 never becomes free, even if retired
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rename_consts.svh"

module free_list (
  input  logic                                      clock,
  input  logic                                      reset,
  input  logic                                      recover,
  input  rename_pkg::prf_mask_t                     recover_free,
  input  logic [`COMMIT_WIDTH-1:0]                  retire_valid,
  input  reg_pkg::prf_index_t [`COMMIT_WIDTH-1:0]   retire_prf,
  alloc_if.provider                                 alloc
);

  rename_pkg::prf_mask_t                      free_map;
  rename_pkg::prf_mask_t                      free_next;
  rename_pkg::prf_mask_t                      remaining;
  reg_pkg::prf_index_t [`RENAME_WIDTH-1:0]    picks;
  int                                         pick_count;

  // Lowest RENAME_WIDTH free registers, one scan per pick
  always_comb begin
    logic found;
    remaining  = free_map;
    pick_count = 0;
    for (int k = 0; k < `RENAME_WIDTH; k++) begin
      picks[k] = '0;
      found    = 1'b0;
      for (int p = 0; p < `PRF_SIZE; p++) begin
        if (!found && remaining[p]) begin
          picks[k]     = reg_pkg::prf_index_t'(p);
          remaining[p] = 1'b0;
          found        = 1'b1;
        end
      end
      if (found) begin
        pick_count = pick_count + 1;
      end
    end
  end

  assign alloc.allocatable = (pick_count == `RENAME_WIDTH);

  // Requesting slots take the picks in order, idle slots do not consume one
  always_comb begin
    int req_seen;
    req_seen = 0;
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      alloc.alloc_prf[i] = picks[req_seen];
      if (alloc.alloc_req[i]) begin
        req_seen = req_seen + 1;
      end
    end
  end

  always_comb begin
    free_next = free_map;
    if (recover) begin
      free_next = recover_free;
    end else if (alloc.alloc_fire) begin
      for (int i = 0; i < `RENAME_WIDTH; i++) begin
        if (alloc.alloc_req[i]) begin
          free_next[alloc.alloc_prf[i]] = 1'b0;
        end
      end
    end
    // Retirements land on top of a recovery load as well
    for (int c = 0; c < `COMMIT_WIDTH; c++) begin
      if (retire_valid[c] && retire_prf[c] != '0) begin
        free_next[retire_prf[c]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      free_map <= {{(`PRF_SIZE-1){1'b1}}, 1'b0};
    end else begin
      free_map <= free_next;
    end
  end

endmodule

`default_nettype wire

//--- rtl/checkpoint_store.sv
////////////////////
// Snapshot bank of the rename table
// Read is combinational, a write shows from the next cycle
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rename_consts.svh"

module checkpoint_store (
  input  logic            clock,
  input  logic            reset,
  checkpoint_if.holder    cp
);

  rename_pkg::map_snapshot_t bank [`CP_COUNT];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `CP_COUNT; i++) begin
        bank[i] <= '0;
      end
    end else if (cp.take) begin
      bank[cp.take_idx] <= cp.snapshot_in;
    end
  end

  assign cp.snapshot_out = bank[cp.restore_idx];

endmodule

`default_nettype wire

//--- rtl/mapping_table.sv
////////////////////
// Rename table with in-group forwarding, slots walked in program order
// Outputs are only meaningful on a cycle where the group fires
// x0 always reads physical 0 and is never renamed
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rename_consts.svh"

module mapping_table (
  input  logic                                      clock,
  input  logic                                      reset,
  input  logic                                      in_valid,
  input  rename_pkg::slot_mask_t                    rd_valid,
  input  reg_pkg::arf_index_t [`RENAME_WIDTH-1:0]   rs1,
  input  reg_pkg::arf_index_t [`RENAME_WIDTH-1:0]   rs2,
  input  reg_pkg::arf_index_t [`RENAME_WIDTH-1:0]   rd,
  input  rename_pkg::slot_mask_t                    check_flag,
  input  reg_pkg::cp_index_t                        check_idx,
  input  logic                                      recover,
  input  reg_pkg::cp_index_t                        recover_idx,
  input  rename_pkg::arf_mask_t                     recover_arf_valid,
  output logic                                      in_ready,
  output reg_pkg::prf_index_t [`RENAME_WIDTH-1:0]   prs1,
  output reg_pkg::prf_index_t [`RENAME_WIDTH-1:0]   prs2,
  output reg_pkg::prf_index_t [`RENAME_WIDTH-1:0]   prd,
  output reg_pkg::prf_index_t [`RENAME_WIDTH-1:0]   prev_rd,
  output rename_pkg::slot_mask_t                    prev_rd_valid,
  alloc_if.requester                                alloc,
  checkpoint_if.writer                              cp
);

  rename_pkg::map_snapshot_t  map_q;
  rename_pkg::map_snapshot_t  map_next;
  rename_pkg::map_snapshot_t  snapshot;
  rename_pkg::arf_mask_t      arf_valid_q;
  rename_pkg::arf_mask_t      arf_valid_next;
  logic                       fire;

  assign in_ready = alloc.allocatable && !recover;
  assign fire     = in_valid && in_ready;

  // Only real destinations need a fresh register
  always_comb begin
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      alloc.alloc_req[i] = rd_valid[i] && (rd[i] != '0);
    end
  end

  assign alloc.alloc_fire = fire;

  always_comb begin
    map_next       = map_q;
    arf_valid_next = arf_valid_q;
    snapshot       = map_q;
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      // Sources see the writes of earlier slots
      prs1[i]          = (rs1[i] == '0) ? '0 : map_next[rs1[i]];
      prs2[i]          = (rs2[i] == '0) ? '0 : map_next[rs2[i]];
      prd[i]           = '0;
      prev_rd[i]       = '0;
      prev_rd_valid[i] = 1'b0;
      if (alloc.alloc_req[i]) begin
        prev_rd[i]          = map_next[rd[i]];
        prev_rd_valid[i]    = arf_valid_next[rd[i]];
        map_next[rd[i]]     = alloc.alloc_prf[i];
        arf_valid_next[rd[i]] = 1'b1;
        prd[i]              = alloc.alloc_prf[i];
      end
      // Last flagged slot wins
      if (check_flag[i]) begin
        snapshot = map_next;
      end
    end
  end

  assign cp.take        = fire && (|check_flag);
  assign cp.take_idx    = check_idx;
  assign cp.snapshot_in = snapshot;
  assign cp.restore_idx = recover_idx;

  always_ff @(posedge clock) begin
    if (reset) begin
      map_q       <= '0;
      arf_valid_q <= rename_pkg::arf_mask_t'(1);
    end else if (recover) begin
      map_q       <= cp.snapshot_out;
      arf_valid_q <= recover_arf_valid;
    end else if (fire) begin
      map_q       <= map_next;
      arf_valid_q <= arf_valid_next;
    end
  end

endmodule

`default_nettype wire

//--- rtl/rename_unit.sv
////////////////////
// Rename stage top. Group handshake is in_valid / in_ready
// Recovery free bitmap and valid vector come from the caller
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rename_consts.svh"

module rename_unit (
  input  logic                                              clock,
  input  logic                                              reset,
  input  logic                                              in_valid,
  input  logic [`RENAME_WIDTH-1:0]                          rd_valid,
  input  logic [`RENAME_WIDTH-1:0][`ARF_INDEX_SIZE-1:0]     rs1,
  input  logic [`RENAME_WIDTH-1:0][`ARF_INDEX_SIZE-1:0]     rs2,
  input  logic [`RENAME_WIDTH-1:0][`ARF_INDEX_SIZE-1:0]     rd,
  input  logic [`RENAME_WIDTH-1:0]                          check_flag,
  input  logic [`CP_INDEX_SIZE-1:0]                         check_idx,
  input  logic                                              recover,
  input  logic [`CP_INDEX_SIZE-1:0]                         recover_idx,
  input  logic [`ARF_SIZE-1:0]                              recover_arf_valid,
  input  logic [`PRF_SIZE-1:0]                              recover_free,
  input  logic [`COMMIT_WIDTH-1:0]                          retire_valid,
  input  logic [`COMMIT_WIDTH-1:0][`PRF_INDEX_SIZE-1:0]     retire_prf,
  output logic                                              in_ready,
  output logic [`RENAME_WIDTH-1:0][`PRF_INDEX_SIZE-1:0]     prs1,
  output logic [`RENAME_WIDTH-1:0][`PRF_INDEX_SIZE-1:0]     prs2,
  output logic [`RENAME_WIDTH-1:0][`PRF_INDEX_SIZE-1:0]     prd,
  output logic [`RENAME_WIDTH-1:0][`PRF_INDEX_SIZE-1:0]     prev_rd,
  output logic [`RENAME_WIDTH-1:0]                          prev_rd_valid
);

  alloc_if      alloc_bus ();
  checkpoint_if cp_bus ();

  mapping_table u_mapping_table (
    .clock             (clock),
    .reset             (reset),
    .in_valid          (in_valid),
    .rd_valid          (rd_valid),
    .rs1               (rs1),
    .rs2               (rs2),
    .rd                (rd),
    .check_flag        (check_flag),
    .check_idx         (check_idx),
    .recover           (recover),
    .recover_idx       (recover_idx),
    .recover_arf_valid (recover_arf_valid),
    .in_ready          (in_ready),
    .prs1              (prs1),
    .prs2              (prs2),
    .prd               (prd),
    .prev_rd           (prev_rd),
    .prev_rd_valid     (prev_rd_valid),
    .alloc             (alloc_bus.requester),
    .cp                (cp_bus.writer)
  );

  free_list u_free_list (
    .clock        (clock),
    .reset        (reset),
    .recover      (recover),
    .recover_free (recover_free),
    .retire_valid (retire_valid),
    .retire_prf   (retire_prf),
    .alloc        (alloc_bus.provider)
  );

  checkpoint_store u_checkpoint_store (
    .clock (clock),
    .reset (reset),
    .cp    (cp_bus.holder)
  );

endmodule

`default_nettype wire

//--- verification/rename_sva.sv
////////////////////
// Handshake and allocation checks, bound into rename_unit
// Only slots that request a register are compared
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rename_consts.svh"

module rename_sva (
  input logic                                     clock,
  input logic                                     reset,
  input logic                                     in_valid,
  input logic                                     in_ready,
  input logic                                     recover,
  input logic [`RENAME_WIDTH-1:0]                 rd_valid,
  input reg_pkg::arf_index_t [`RENAME_WIDTH-1:0]  rd,
  input reg_pkg::prf_index_t [`RENAME_WIDTH-1:0]  prd,
  input logic [`COMMIT_WIDTH-1:0]                 retire_valid,
  input reg_pkg::prf_index_t [`COMMIT_WIDTH-1:0]  retire_prf
);

  logic                   fire;
  rename_pkg::slot_mask_t req;
  logic                   prd_distinct;
  logic                   retire_clash;

  assign fire = in_valid && in_ready;

  always_comb begin
    prd_distinct = 1'b1;
    retire_clash = 1'b0;
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      req[i] = rd_valid[i] && (rd[i] != '0);
    end
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      for (int j = i + 1; j < `RENAME_WIDTH; j++) begin
        if (req[i] && req[j] && prd[i] == prd[j]) begin
          prd_distinct = 1'b0;
        end
      end
      for (int c = 0; c < `COMMIT_WIDTH; c++) begin
        if (req[i] && retire_valid[c] && prd[i] == retire_prf[c]) begin
          retire_clash = 1'b1;
        end
      end
    end
  end

  ready_low_in_recovery: assert property (@(posedge clock) disable iff (reset)
    recover |-> !in_ready) else $error("in_ready is high during recovery");

  distinct_prd: assert property (@(posedge clock) disable iff (reset)
    fire |-> prd_distinct) else $error("two slots received the same physical register");

  no_retire_clash: assert property (@(posedge clock) disable iff (reset)
    fire |-> !retire_clash) else $error("a register was allocated while being retired");

endmodule

bind rename_unit rename_sva rename_sva_inst (
  .clock        (clock),
  .reset        (reset),
  .in_valid     (in_valid),
  .in_ready     (in_ready),
  .recover      (recover),
  .rd_valid     (rd_valid),
  .rd           (rd),
  .prd          (prd),
  .retire_valid (retire_valid),
  .retire_prf   (retire_prf)
);

`default_nettype wire

//--- verification/rename_tb.sv
////////////////////
// Random testbench of the rename stage against a reference model
// Recovery hands back the model's current free bitmap, so registers
// renamed after a checkpoint stay allocated until the run ends
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rename_consts.svh"

module rename_tb;

  localparam int CLOCK_PERIOD  = 8;
  localparam int RANDOM_GROUPS = 160;
  // Random groups plus reset, exhaustion and checkpoint rounds
  localparam int GROUP_COUNT   = RANDOM_GROUPS + 100;

  logic                                     clock = 1'b0;
  logic                                     reset;
  logic                                     in_valid;
  rename_pkg::slot_mask_t                   rd_valid;
  reg_pkg::arf_index_t [`RENAME_WIDTH-1:0]  rs1;
  reg_pkg::arf_index_t [`RENAME_WIDTH-1:0]  rs2;
  reg_pkg::arf_index_t [`RENAME_WIDTH-1:0]  rd;
  rename_pkg::slot_mask_t                   check_flag;
  reg_pkg::cp_index_t                       check_idx;
  logic                                     recover;
  reg_pkg::cp_index_t                       recover_idx;
  rename_pkg::arf_mask_t                    recover_arf_valid;
  rename_pkg::prf_mask_t                    recover_free;
  logic [`COMMIT_WIDTH-1:0]                 retire_valid;
  reg_pkg::prf_index_t [`COMMIT_WIDTH-1:0]  retire_prf;
  logic                                     in_ready;
  reg_pkg::prf_index_t [`RENAME_WIDTH-1:0]  prs1;
  reg_pkg::prf_index_t [`RENAME_WIDTH-1:0]  prs2;
  reg_pkg::prf_index_t [`RENAME_WIDTH-1:0]  prd;
  reg_pkg::prf_index_t [`RENAME_WIDTH-1:0]  prev_rd;
  rename_pkg::slot_mask_t                   prev_rd_valid;

  // Reference model
  rename_pkg::map_snapshot_t  m_map;
  rename_pkg::arf_mask_t      m_valid;
  rename_pkg::prf_mask_t      in_use;
  rename_pkg::map_snapshot_t  m_snap [`CP_COUNT];
  reg_pkg::prf_index_t        retire_q [$];
  logic                       last_ready;
  logic                       fired;
  logic                       full_dest;

  rename_unit rename_unit_inst (
    .clock (clock), .reset (reset), .in_valid (in_valid), .rd_valid (rd_valid),
    .rs1 (rs1), .rs2 (rs2), .rd (rd), .check_flag (check_flag), .check_idx (check_idx),
    .recover (recover), .recover_idx (recover_idx), .recover_arf_valid (recover_arf_valid),
    .recover_free (recover_free), .retire_valid (retire_valid), .retire_prf (retire_prf),
    .in_ready (in_ready), .prs1 (prs1), .prs2 (prs2), .prd (prd), .prev_rd (prev_rd),
    .prev_rd_valid (prev_rd_valid)
  );

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input int got, input int expected);
    assert (got == expected) else
      fail_now($sformatf("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, expected));
  endtask

  // Drive one group at the rising edge, check it at the falling edge
  task automatic step(input logic valid, input logic take, input int retire_n,
                      input logic rec, input reg_pkg::cp_index_t idx);
    rename_pkg::map_snapshot_t                map_t;
    rename_pkg::map_snapshot_t                snap_t;
    rename_pkg::arf_mask_t                    valid_t;
    rename_pkg::prf_mask_t                    gone;
    reg_pkg::prf_index_t                      p;
    logic [`COMMIT_WIDTH-1:0]                 ret_v;
    reg_pkg::prf_index_t [`COMMIT_WIDTH-1:0]  ret_p;
    @(posedge clock);
    gone  = '0;
    ret_v = '0;
    ret_p = '0;
    for (int c = 0; c < `COMMIT_WIDTH; c++) begin
      if (c < retire_n && retire_q.size() > 0) begin
        p = retire_q.pop_front();
        // Stale or repeated entries are dropped
        if (in_use[p] && !gone[p]) begin
          ret_v[c] = 1'b1;
          ret_p[c] = p;
          gone[p]  = 1'b1;
        end
      end
    end
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      rs1[i]      <= reg_pkg::arf_index_t'($urandom_range(0, `ARF_SIZE - 1));
      rs2[i]      <= reg_pkg::arf_index_t'($urandom_range(0, `ARF_SIZE - 1));
      rd[i]       <= reg_pkg::arf_index_t'($urandom_range(full_dest ? 1 : 0, `ARF_SIZE - 1));
      rd_valid[i] <= full_dest || ($urandom_range(0, 3) != 0);
    end
    in_valid          <= valid;
    check_flag        <= take ? rename_pkg::slot_mask_t'($urandom_range(1, 3)) : '0;
    check_idx         <= idx;
    recover           <= rec;
    recover_idx       <= idx;
    recover_arf_valid <= m_valid;
    recover_free      <= ~in_use;
    retire_valid      <= ret_v;
    retire_prf        <= ret_p;
    @(negedge clock);
    check_value("in_ready", int'(in_ready),
                int'($countones(~in_use) >= `RENAME_WIDTH && !rec));
    last_ready = in_ready;
    fired      = in_valid && in_ready;
    if (fired) begin
      map_t   = m_map;
      valid_t = m_valid;
      snap_t  = m_map;
      for (int i = 0; i < `RENAME_WIDTH; i++) begin
        check_value($sformatf("prs1[%0d]", i), int'(prs1[i]),
                    (rs1[i] == '0) ? 0 : int'(map_t[rs1[i]]));
        check_value($sformatf("prs2[%0d]", i), int'(prs2[i]),
                    (rs2[i] == '0) ? 0 : int'(map_t[rs2[i]]));
        if (rd_valid[i] && rd[i] != '0) begin
          check_value($sformatf("prev_rd[%0d]", i), int'(prev_rd[i]), int'(map_t[rd[i]]));
          check_value($sformatf("prev_rd_valid[%0d]", i), int'(prev_rd_valid[i]),
                      int'(valid_t[rd[i]]));
          assert (prd[i] != '0 && !in_use[prd[i]]) else
            fail_now($sformatf("prd[%0d] = %0d at %0t is zero or already in use",
                               i, prd[i], $time));
          in_use[prd[i]] = 1'b1;
          if (valid_t[rd[i]] && map_t[rd[i]] != '0) begin
            retire_q.push_back(map_t[rd[i]]);
          end
          map_t[rd[i]]   = prd[i];
          valid_t[rd[i]] = 1'b1;
        end
        if (check_flag[i]) begin
          snap_t = map_t;
        end
      end
      m_map   = map_t;
      m_valid = valid_t;
      if (|check_flag) begin
        m_snap[check_idx] = snap_t;
      end
    end
    if (rec) begin
      m_map = m_snap[idx];
    end
    in_use = in_use & ~gone;
  endtask

  initial begin
    void'($urandom(32'h2d5cdf30));
    reset <= 1'b1;
    in_valid <= 1'b0;
    rd_valid <= '0;
    rs1 <= '0;
    rs2 <= '0;
    rd <= '0;
    check_flag <= '0;
    check_idx <= '0;
    recover <= 1'b0;
    recover_idx <= '0;
    recover_arf_valid <= '0;
    recover_free <= '0;
    retire_valid <= '0;
    retire_prf <= '0;
    full_dest = 1'b0;
    m_map     = '0;
    m_valid   = rename_pkg::arf_mask_t'(1);
    in_use    = rename_pkg::prf_mask_t'(1);
    for (int k = 0; k < `CP_COUNT; k++) begin
      m_snap[k] = '0;
    end
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    // First group sees the reset table
    step(1'b1, 1'b0, 0, 1'b0, '0);
    for (int g = 0; g < RANDOM_GROUPS; g++) begin
      step($urandom_range(0, 4) != 0, $urandom_range(0, 7) == 0, $urandom_range(0, 2), 1'b0,
           reg_pkg::cp_index_t'($urandom_range(0, `CP_COUNT - 1)));
    end
    // Exhaust the free list, then retire until groups are accepted again
    full_dest = 1'b1;
    while (last_ready) begin
      step(1'b1, 1'b0, 0, 1'b0, '0);
    end
    full_dest = 1'b0;
    while (!last_ready) begin
      step(1'b0, 1'b0, 2, 1'b0, '0);
    end
    for (int r = 0; r < `CP_COUNT; r++) begin
      fired = 1'b0;
      while (!fired) begin
        step(1'b1, 1'b1, 2, 1'b0, reg_pkg::cp_index_t'(r));
      end
      repeat (3) step(1'b1, 1'b0, 2, 1'b0, '0);
      step(1'b0, 1'b0, 0, 1'b1, reg_pkg::cp_index_t'(r));
      repeat (2) step(1'b1, 1'b0, 2, 1'b0, '0);
    end
    $display("TESTS PASSED");
    $finish;
  end

  initial begin
    #(GROUP_COUNT * 20 * CLOCK_PERIOD);
    fail_now("timeout: the rename stage stopped accepting groups");
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+rtl
rtl/reg_pkg.sv
rtl/rename_pkg.sv
rtl/rename_ifs.sv
rtl/free_list.sv
rtl/checkpoint_store.sv
rtl/mapping_table.sv
rtl/rename_unit.sv
verification/rename_sva.sv
verification/rename_tb.sv

//--- Makefile
# Verilator build and run of the rename stage testbench

VERILATOR ?= verilator
TOP       ?= rename_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# Passes only when the run prints the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
